// ==== hw/arcade_input_pkg.sv ====
/*
 * Shared constants for the arcade input and timing section.
 * Widths, download indexes, clock divider periods, joystick bit
 * positions and game variant codes. Modules import it by wildcard.
 */
`default_nettype none

package arcade_input_pkg;

	// ================================================
	// Widths
	// ================================================
	localparam int BYTE_W        = 8;
	localparam int DN_ADDR_W     = 25;
	localparam int JOY_W         = 16;
	localparam int DIR_W         = 4;

	// Download stream indexes
	localparam int IDX_VARIANT   = 1;
	localparam int IDX_SWITCH    = 254;
	localparam int SWITCH_COUNT  = 8;

	// Enable periods in clk_sys cycles
	localparam int DIV_6M        = 4;
	localparam int DIV_4M        = 6;
	localparam int DIV_1M79      = 13;

	// Joystick word layout
	localparam int JOY_RIGHT     = 0;
	localparam int JOY_LEFT      = 1;
	localparam int JOY_DOWN      = 2;
	localparam int JOY_UP        = 3;
	localparam int JOY_FIRE      = 4;
	localparam int JOY_START1    = 5;
	localparam int JOY_START2    = 6;
	localparam int JOY_COIN      = 7;
	localparam int JOY_CHEAT     = 8;

	// ================================================
	// Game variants, code equals flag bit
	// ================================================
	localparam int VARIANT_COUNT = 18;
	localparam int V_ORIG  = 0;
	localparam int V_PLUS  = 1;
	localparam int V_CLUB  = 2;
	localparam int V_BIRD  = 4;
	localparam int V_MS    = 5;
	localparam int V_GORK  = 6;
	localparam int V_MRTNT = 7;
	localparam int V_WOODP = 8;
	localparam int V_EEEK  = 9;
	localparam int V_ALIB  = 10;
	localparam int V_PONP  = 11;
	localparam int V_VAN   = 12;
	localparam int V_PMM   = 13;
	localparam int V_DSHOP = 14;
	localparam int V_GLOB  = 15;
	localparam int V_JMPST = 16;
	localparam int V_NUMCR = 17;

	// Port inversion masks
	localparam logic [BYTE_W-1:0] IN0_XOR_DEFAULT = 8'hFF;
	localparam logic [BYTE_W-1:0] IN0_XOR_PONP    = 8'hE0;
	localparam logic [BYTE_W-1:0] IN1_XOR_DEFAULT = 8'hFF;
	localparam logic [BYTE_W-1:0] IN1_XOR_PONP    = 8'h00;

endpackage

`default_nettype wire

// ==== hw/player_ctrl_if.sv ====
/*
 * Filtered controls of both players.
 * Driven by the input filter stage, read by the port mapper.
 */
`timescale 1ns/1ps
`default_nettype none

interface player_ctrl_if;
	import arcade_input_pkg::*;

	// Directions, bit 0 right up to bit 3 up
	logic [DIR_W-1:0] dir_p1;
	logic [DIR_W-1:0] dir_p2;
	logic             fire_p1;
	logic             fire_p2;

	// Shared buttons, already merged over both players
	logic             start1;
	logic             start2;
	logic             coin;
	logic             cheat;

	modport source (output dir_p1, dir_p2, fire_p1, fire_p2, start1, start2, coin, cheat);
	modport sink   (input  dir_p1, dir_p2, fire_p1, fire_p2, start1, start2, coin, cheat);

endinterface

`default_nettype wire

// ==== hw/clock_enables.sv ====
/*
 * Clock enable generator.
 * Produces the 6 MHz, 4 MHz and 1.79 MHz single-cycle strobes from clk_sys.
 * Each strobe is high in the first cycle after reset and once per period.
 */
`timescale 1ns/1ps
`default_nettype none

module clock_enables (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_6m,
	output logic ce_4m,
	output logic ce_1m79
);
	import arcade_input_pkg::*;

	localparam int CNT_W = $clog2(DIV_1M79);
	localparam int PERIOD [3] = '{DIV_6M, DIV_4M, DIV_1M79};

	logic [2:0] strobe;

	// One wrapping counter per enable
	for (genvar g = 0; g < 3; g++) begin : gen_div
		logic [CNT_W-1:0] count;

		always_ff @(posedge clk_sys) begin
			if (reset)
				count <= '0;
			else if (count == CNT_W'(PERIOD[g] - 1))
				count <= '0;
			else
				count <= count + 1'b1;
		end

		assign strobe[g] = (count == '0);
	end

	assign ce_6m   = strobe[0];
	assign ce_4m   = strobe[1];
	assign ce_1m79 = strobe[2];

	// Pixel enable must be a single-cycle pulse
	a_ce_6m_single: assert property (@(posedge clk_sys) disable iff (reset)
		ce_6m |=> !ce_6m);

endmodule

`default_nettype wire

// ==== hw/download_regs.sv ====
/*
 * Download stream capture.
 * Index 1 writes the game variant byte, index 254 writes the switch bytes.
 * The variant byte is decoded into registered one-hot flags.
 */
`timescale 1ns/1ps
`default_nettype none

module download_regs (
	input  logic                                      clk_sys,
	input  logic                                      reset,
	input  logic                                      dn_wr,
	input  logic [arcade_input_pkg::BYTE_W-1:0]       dn_index,
	input  logic [arcade_input_pkg::DN_ADDR_W-1:0]    dn_addr,
	input  logic [arcade_input_pkg::BYTE_W-1:0]       dn_data,
	output logic [arcade_input_pkg::VARIANT_COUNT-1:0] variant_flags,
	output logic [arcade_input_pkg::BYTE_W-1:0]       sw0,
	output logic [arcade_input_pkg::BYTE_W-1:0]       sw1,
	output logic [arcade_input_pkg::BYTE_W-1:0]       sw2,
	output logic [arcade_input_pkg::BYTE_W-1:0]       sw3
);
	import arcade_input_pkg::*;

	localparam int SW_SEL_W = $clog2(SWITCH_COUNT);

	logic [BYTE_W-1:0] variant_code;
	logic [BYTE_W-1:0] sw [SWITCH_COUNT];
	logic              wr_variant;
	logic              wr_switch;
	logic              code_known;

	assign wr_variant = dn_wr && (dn_index == BYTE_W'(IDX_VARIANT));
	// Only the first eight addresses of the switch block are stored
	assign wr_switch  = dn_wr && (dn_index == BYTE_W'(IDX_SWITCH))
		&& (dn_addr[DN_ADDR_W-1:SW_SEL_W] == '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			variant_code <= '0;
			for (int i = 0; i < SWITCH_COUNT; i++)
				sw[i] <= '1;
		end else begin
			if (wr_variant)
				variant_code <= dn_data;
			if (wr_switch)
				sw[dn_addr[SW_SEL_W-1:0]] <= dn_data;
		end
	end

	// Codes outside this list leave every flag low
	assign code_known = variant_code inside {V_ORIG, V_PLUS, V_CLUB, V_BIRD, V_MS, V_GORK,
		V_MRTNT, V_WOODP, V_EEEK, V_ALIB, V_PONP, V_VAN, V_PMM, V_DSHOP, V_GLOB,
		V_JMPST, V_NUMCR};

	always_ff @(posedge clk_sys) begin
		if (reset)
			variant_flags <= VARIANT_COUNT'(1) << V_ORIG;
		else
			for (int i = 0; i < VARIANT_COUNT; i++)
				variant_flags[i] <= code_known && (variant_code == BYTE_W'(i));
	end

	assign sw0 = sw[0];
	assign sw1 = sw[1];
	assign sw2 = sw[2];
	assign sw3 = sw[3];

	a_variant_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(variant_flags));

endmodule

`default_nettype wire

// ==== hw/joy_one_dir.sv ====
/*
 * Four-way joystick filter for one player.
 * Passes only the most recently pressed direction while it is held.
 * single_dir_off lets every held direction through.
 */
`timescale 1ns/1ps
`default_nettype none

module joy_one_dir (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               single_dir_off,
	input  logic [arcade_input_pkg::DIR_W-1:0] dir_raw,
	output logic [arcade_input_pkg::DIR_W-1:0] dir_out
);
	import arcade_input_pkg::*;

	logic [DIR_W-1:0] in_q1;
	logic [DIR_W-1:0] in_q2;
	logic [DIR_W-1:0] mask;
	logic [DIR_W-1:0] pressed_new;

	// Rising edge of each direction
	assign pressed_new = in_q1 & ~in_q2;
	assign dir_out     = in_q1 & mask;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in_q1 <= '0;
			in_q2 <= '0;
			mask  <= '1;
		end else begin
			in_q1 <= dir_raw;
			in_q2 <= in_q1;
			// Ascending scan, so the highest new press wins
			for (int i = 0; i < DIR_W; i++)
				if (pressed_new[i])
					mask <= DIR_W'(1) << i;
			// Reopen all directions once the selected one is let go
			if (single_dir_off || ((dir_raw & mask) == '0))
				mask <= '1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/player_inputs.sv ====
/*
 * Player input stage.
 * Runs both joysticks through the four-way filter and registers the
 * buttons so they line up with the filtered directions.
 */
`timescale 1ns/1ps
`default_nettype none

module player_inputs (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               single_dir_off,
	input  logic [arcade_input_pkg::JOY_W-1:0] joy_p1,
	input  logic [arcade_input_pkg::JOY_W-1:0] joy_p2,
	player_ctrl_if.source                      ctrl
);
	import arcade_input_pkg::*;

	logic [DIR_W-1:0] dir_raw_p1;
	logic [DIR_W-1:0] dir_raw_p2;

	assign dir_raw_p1 = {joy_p1[JOY_UP], joy_p1[JOY_DOWN], joy_p1[JOY_LEFT], joy_p1[JOY_RIGHT]};
	assign dir_raw_p2 = {joy_p2[JOY_UP], joy_p2[JOY_DOWN], joy_p2[JOY_LEFT], joy_p2[JOY_RIGHT]};

	joy_one_dir filt_p1 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.single_dir_off (single_dir_off),
		.dir_raw        (dir_raw_p1),
		.dir_out        (ctrl.dir_p1)
	);

	joy_one_dir filt_p2 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.single_dir_off (single_dir_off),
		.dir_raw        (dir_raw_p2),
		.dir_out        (ctrl.dir_p2)
	);

	// Same one-cycle delay as the filter input register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl.fire_p1 <= 1'b0;
			ctrl.fire_p2 <= 1'b0;
			ctrl.start1  <= 1'b0;
			ctrl.start2  <= 1'b0;
			ctrl.coin    <= 1'b0;
			ctrl.cheat   <= 1'b0;
		end else begin
			ctrl.fire_p1 <= joy_p1[JOY_FIRE];
			ctrl.fire_p2 <= joy_p2[JOY_FIRE];
			ctrl.start1  <= joy_p1[JOY_START1] | joy_p2[JOY_START1];
			ctrl.start2  <= joy_p1[JOY_START2] | joy_p2[JOY_START2];
			ctrl.coin    <= joy_p1[JOY_COIN] | joy_p2[JOY_COIN];
			ctrl.cheat   <= joy_p1[JOY_CHEAT] | joy_p2[JOY_CHEAT];
		end
	end

endmodule

`default_nettype wire

// ==== hw/control_mapper.sv ====
/*
 * Input port mapper.
 * Builds the active-low in0 and in1 bytes per game variant and
 * selects the DIP bytes. Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	player_ctrl_if.sink                                ctrl,
	input  logic [arcade_input_pkg::VARIANT_COUNT-1:0] variant_flags,
	input  logic [arcade_input_pkg::BYTE_W-1:0]        sw0,
	input  logic [arcade_input_pkg::BYTE_W-1:0]        sw1,
	input  logic [arcade_input_pkg::BYTE_W-1:0]        sw2,
	input  logic [arcade_input_pkg::BYTE_W-1:0]        sw3,
	output logic [arcade_input_pkg::BYTE_W-1:0]        in0,
	output logic [arcade_input_pkg::BYTE_W-1:0]        in1,
	output logic [arcade_input_pkg::BYTE_W-1:0]        dipsw1,
	output logic [arcade_input_pkg::BYTE_W-1:0]        dipsw2
);
	import arcade_input_pkg::*;

	logic numcr, pmm, eeek, alib, jmpst, gm;
	logic cheat_en, fire_on_cheat, p2_fire_on_b4, dip2_used;
	logic [BYTE_W-1:0] in0_tbl;
	logic [BYTE_W-1:0] in1_tbl;
	logic [BYTE_W-1:0] in0_xor;
	logic [BYTE_W-1:0] in1_xor;

	assign numcr = variant_flags[V_NUMCR];
	assign pmm   = variant_flags[V_PMM];
	assign eeek  = variant_flags[V_EEEK];
	assign alib  = variant_flags[V_ALIB];
	assign jmpst = variant_flags[V_JMPST];
	assign gm    = variant_flags[V_GORK] | variant_flags[V_MRTNT];

	// Variants that honour the cheat button
	assign cheat_en = variant_flags[V_ORIG] | variant_flags[V_PLUS] | variant_flags[V_MS]
		| variant_flags[V_BIRD] | alib | variant_flags[V_WOODP] | numcr;
	// Ponpoko family reads fire where the others read cheat
	assign fire_on_cheat = variant_flags[V_PONP] | variant_flags[V_VAN] | variant_flags[V_DSHOP];
	assign p2_fire_on_b4 = alib | fire_on_cheat;
	assign dip2_used     = numcr | fire_on_cheat;

	// ================================================
	// in0, player 1 and coin
	// ================================================
	always_comb begin
		in0_tbl[0] = ctrl.dir_p1[0 + 3];
		// Number Crash has left and right swapped
		in0_tbl[1] = numcr ? ctrl.dir_p1[0] : ctrl.dir_p1[1];
		in0_tbl[2] = numcr ? ctrl.dir_p1[1] : ctrl.dir_p1[0];
		in0_tbl[3] = ctrl.dir_p1[2];
		in0_tbl[4] = (cheat_en & ctrl.cheat) | (fire_on_cheat & ctrl.fire_p1);
		in0_tbl[5] = ~numcr & ctrl.coin;
		in0_tbl[6] = (alib & ctrl.fire_p1) | numcr;
		in0_tbl[7] = eeek & ctrl.fire_p2;
	end

	// ================================================
	// in1, player 2 and start
	// ================================================
	always_comb begin
		in1_tbl[0] = (~pmm & ctrl.dir_p2[3]) | (numcr & ctrl.fire_p1);
		in1_tbl[1] = ~pmm & ctrl.dir_p2[1];
		// PMM uses this bit for its fire button
		in1_tbl[2] = pmm ? ctrl.fire_p1 : ctrl.dir_p2[0];
		in1_tbl[3] = ~pmm & ctrl.dir_p2[2];
		in1_tbl[4] = (gm & ctrl.fire_p1) | (p2_fire_on_b4 & ctrl.fire_p2);
		in1_tbl[5] = (~numcr & ctrl.start1) | (jmpst & ctrl.fire_p1) | (numcr & ctrl.coin);
		in1_tbl[6] = ctrl.start2 | (eeek & ctrl.fire_p1) | (jmpst & ctrl.fire_p2)
			| (numcr & ctrl.start1);
		in1_tbl[7] = gm & ctrl.fire_p2;
	end

	// Ponpoko reads most of its inputs active high
	assign in0_xor = variant_flags[V_PONP] ? IN0_XOR_PONP : IN0_XOR_DEFAULT;
	assign in1_xor = variant_flags[V_PONP] ? IN1_XOR_PONP : IN1_XOR_DEFAULT;

	assign in0    = sw0 & (in0_xor ^ in0_tbl);
	assign in1    = sw1 & (in1_xor ^ in1_tbl);
	assign dipsw1 = sw2;
	assign dipsw2 = dip2_used ? sw3 : '1;

endmodule

`default_nettype wire

// ==== hw/arcade_input_top.sv ====
/*
 * Input and timing section of the arcade core.
 * Clock enables, download registers, joystick filtering and port mapping
 * behind plain ports. Instances and wiring only.
 */
`timescale 1ns/1ps
`default_nettype none

module arcade_input_top (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  logic                                   dn_wr,
	input  logic [arcade_input_pkg::BYTE_W-1:0]    dn_index,
	input  logic [arcade_input_pkg::DN_ADDR_W-1:0] dn_addr,
	input  logic [arcade_input_pkg::BYTE_W-1:0]    dn_data,
	input  logic [arcade_input_pkg::JOY_W-1:0]     joy_p1,
	input  logic [arcade_input_pkg::JOY_W-1:0]     joy_p2,
	output logic                                   ce_6m,
	output logic                                   ce_4m,
	output logic                                   ce_1m79,
	output logic [arcade_input_pkg::BYTE_W-1:0]    in0,
	output logic [arcade_input_pkg::BYTE_W-1:0]    in1,
	output logic [arcade_input_pkg::BYTE_W-1:0]    dipsw1,
	output logic [arcade_input_pkg::BYTE_W-1:0]    dipsw2
);
	import arcade_input_pkg::*;

	logic [VARIANT_COUNT-1:0] variant_flags;
	logic [BYTE_W-1:0]        sw0, sw1, sw2, sw3;

	player_ctrl_if ctrl_bus ();

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_6m   (ce_6m),
		.ce_4m   (ce_4m),
		.ce_1m79 (ce_1m79)
	);

	download_regs u_download_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dn_wr         (dn_wr),
		.dn_index      (dn_index),
		.dn_addr       (dn_addr),
		.dn_data       (dn_data),
		.variant_flags (variant_flags),
		.sw0           (sw0),
		.sw1           (sw1),
		.sw2           (sw2),
		.sw3           (sw3)
	);

	// Birdiy plays with an eight-way stick
	player_inputs u_player_inputs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.single_dir_off (variant_flags[V_BIRD]),
		.joy_p1         (joy_p1),
		.joy_p2         (joy_p2),
		.ctrl           (ctrl_bus)
	);

	control_mapper u_control_mapper (
		.ctrl          (ctrl_bus),
		.variant_flags (variant_flags),
		.sw0           (sw0),
		.sw1           (sw1),
		.sw2           (sw2),
		.sw3           (sw3),
		.in0           (in0),
		.in1           (in1),
		.dipsw1        (dipsw1),
		.dipsw2        (dipsw2)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_arcade_input.sv ====
/*
 * Self-checking testbench for the arcade input and timing section.
 * A cycle model of the registers feeds a reference function, and a
 * compare process checks every port of the DUT on each falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_input;
	import arcade_input_pkg::*;

	localparam int CLK_PERIOD    = 4;
	localparam int TEST_CYCLES   = 4 + 200 + 20 + 20 + 17 * 4 + 16 + 8;
	localparam int MARGIN_CYCLES = 100;

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic                 dn_wr;
	logic [BYTE_W-1:0]    dn_index;
	logic [DN_ADDR_W-1:0] dn_addr;
	logic [BYTE_W-1:0]    dn_data;
	logic [JOY_W-1:0]     joy_p1;
	logic [JOY_W-1:0]     joy_p2;
	logic                 ce_6m, ce_4m, ce_1m79;
	logic [BYTE_W-1:0]    in0, in1, dipsw1, dipsw2;

	string       test_name = "reset";
	int          errors = 0;
	int          checks = 0;
	int unsigned seed_init;
	int          variant_list [17] = '{V_ORIG, V_PLUS, V_CLUB, V_BIRD, V_MS, V_GORK, V_MRTNT,
		V_WOODP, V_EEEK, V_ALIB, V_PONP, V_VAN, V_PMM, V_DSHOP, V_GLOB, V_JMPST, V_NUMCR};
	logic [BYTE_W-1:0] sw_rand [SWITCH_COUNT];

	// Model state with one entry per DUT register
	int               m_k;
	int               m_act;
	logic [BYTE_W-1:0] m_code;
	logic [BYTE_W-1:0] m_sw [SWITCH_COUNT];
	logic [DIR_W-1:0]  m_q1 [2];
	logic [DIR_W-1:0]  m_q2 [2];
	logic [DIR_W-1:0]  m_mask [2];
	logic              m_fire [2];
	logic              m_st1, m_st2, m_coin, m_cheat;

	arcade_input_top DUT (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [DIR_W-1:0] dirs_of(input logic [JOY_W-1:0] joy);
		return {joy[JOY_UP], joy[JOY_DOWN], joy[JOY_LEFT], joy[JOY_RIGHT]};
	endfunction

	// Newest press takes the mask and a released or disabled mask reopens
	function automatic logic [DIR_W-1:0] next_mask(input logic [DIR_W-1:0] q1, q2, mask, raw,
		input logic off);
		logic [DIR_W-1:0] m;
		m = mask;
		for (int i = 0; i < DIR_W; i++)
			if (q1[i] && !q2[i])
				m = DIR_W'(1) << i;
		if (off || (raw & mask) == '0)
			m = '1;
		return m;
	endfunction

	// Expected {in0, in1, dipsw1, dipsw2}
	function automatic logic [4*BYTE_W-1:0] ref_ports(input int code,
		input logic [BYTE_W-1:0] s0, s1, s2, s3, input logic [DIR_W-1:0] d1, d2,
		input logic f1, f2, st1, st2, coin, cheat);
		logic num, pmm, eeek, alib, jmp, gm, chen, foc, ponp;
		logic [BYTE_W-1:0] t0, t1, x0, x1, dip2;
		num  = (code == V_NUMCR);
		pmm  = (code == V_PMM);
		eeek = (code == V_EEEK);
		alib = (code == V_ALIB);
		jmp  = (code == V_JMPST);
		ponp = (code == V_PONP);
		gm   = (code == V_GORK) || (code == V_MRTNT);
		chen = code inside {V_ORIG, V_PLUS, V_MS, V_BIRD, V_ALIB, V_WOODP, V_NUMCR};
		foc  = code inside {V_PONP, V_VAN, V_DSHOP};
		t0 = {eeek & f2, (alib & f1) | num, ~num & coin, (chen & cheat) | (foc & f1),
			d1[2], num ? d1[1] : d1[0], num ? d1[0] : d1[1], d1[3]};
		t1 = {gm & f2, st2 | (eeek & f1) | (jmp & f2) | (num & st1),
			(~num & st1) | (jmp & f1) | (num & coin), (gm & f1) | ((alib | foc) & f2),
			~pmm & d2[2], pmm ? f1 : d2[0], ~pmm & d2[1], (~pmm & d2[3]) | (num & f1)};
		x0 = ponp ? IN0_XOR_PONP : IN0_XOR_DEFAULT;
		x1 = ponp ? IN1_XOR_PONP : IN1_XOR_DEFAULT;
		dip2 = (num || foc) ? s3 : '1;
		return {s0 & (x0 ^ t0), s1 & (x1 ^ t1), s2, dip2};
	endfunction

	task automatic check_byte(input string what, input logic [BYTE_W-1:0] exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH test=%s %s expected=%h actual=%h", test_name, what, exp, act);
		end
	endtask

	task automatic check_strobes(input logic [2:0] exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH test=%s strobes expected=%b actual=%b", test_name, exp, act);
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic dn_write(input logic [BYTE_W-1:0] idx, input logic [DN_ADDR_W-1:0] addr,
		input logic [BYTE_W-1:0] data);
		dn_wr    = 1'b1;
		dn_index = idx;
		dn_addr  = addr;
		dn_data  = data;
		step(1);
		dn_wr    = 1'b0;
	endtask

	// ================================================
	// Cycle model of the DUT registers
	// ================================================
	always @(posedge clk_sys) begin
		logic [DIR_W-1:0] raw;
		if (reset) begin
			m_k <= 0;
			m_act <= V_ORIG;
			m_code <= '0;
			for (int i = 0; i < SWITCH_COUNT; i++)
				m_sw[i] <= '1;
			for (int p = 0; p < 2; p++) begin
				m_q1[p] <= '0;
				m_q2[p] <= '0;
				m_mask[p] <= '1;
				m_fire[p] <= 1'b0;
			end
			{m_st1, m_st2, m_coin, m_cheat} <= '0;
		end else begin
			m_k <= m_k + 1;
			if (dn_wr && dn_index == BYTE_W'(IDX_VARIANT))
				m_code <= dn_data;
			if (dn_wr && dn_index == BYTE_W'(IDX_SWITCH) && dn_addr[DN_ADDR_W-1:3] == '0)
				m_sw[dn_addr[2:0]] <= dn_data;
			m_act <= (m_code < VARIANT_COUNT && m_code != 3) ? int'(m_code) : -1;
			for (int p = 0; p < 2; p++) begin
				raw = dirs_of(p == 0 ? joy_p1 : joy_p2);
				m_q1[p] <= raw;
				m_q2[p] <= m_q1[p];
				m_mask[p] <= next_mask(m_q1[p], m_q2[p], m_mask[p], raw, m_act == V_BIRD);
			end
			m_fire[0] <= joy_p1[JOY_FIRE];
			m_fire[1] <= joy_p2[JOY_FIRE];
			m_st1   <= joy_p1[JOY_START1] | joy_p2[JOY_START1];
			m_st2   <= joy_p1[JOY_START2] | joy_p2[JOY_START2];
			m_coin  <= joy_p1[JOY_COIN] | joy_p2[JOY_COIN];
			m_cheat <= joy_p1[JOY_CHEAT] | joy_p2[JOY_CHEAT];
		end
	end

	// Compare at the falling edge once every DUT output has settled
	always @(negedge clk_sys) begin
		logic [4*BYTE_W-1:0] e;
		if (!reset) begin
			e = ref_ports(m_act, m_sw[0], m_sw[1], m_sw[2], m_sw[3], m_q1[0] & m_mask[0],
				m_q1[1] & m_mask[1], m_fire[0], m_fire[1], m_st1, m_st2, m_coin, m_cheat);
			check_byte("in0", e[31:24], in0);
			check_byte("in1", e[23:16], in1);
			check_byte("dipsw1", e[15:8], dipsw1);
			check_byte("dipsw2", e[7:0], dipsw2);
			check_strobes({m_k % DIV_1M79 == 0, m_k % DIV_4M == 0, m_k % DIV_6M == 0},
				{ce_1m79, ce_4m, ce_6m});
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// ================================================
	// Stimulus
	// ================================================
	initial begin
		seed_init = $urandom(82);
		reset = 1'b1;
		dn_wr = 1'b0;
		dn_index = '0;
		dn_addr = '0;
		dn_data = '0;
		joy_p1 = '0;
		joy_p2 = '0;
		step(4);
		reset = 1'b0;

		test_name = "strobe periods";
		check_byte("in0 idle", 8'hFF, in0);
		check_byte("in1 idle", 8'hFF, in1);
		step(200);

		test_name = "switch loading";
		for (int i = 0; i < SWITCH_COUNT; i++) begin
			sw_rand[i] = BYTE_W'($urandom);
			dn_write(IDX_SWITCH, DN_ADDR_W'(i), sw_rand[i]);
		end
		check_byte("in0 switches", sw_rand[0], in0);
		check_byte("dipsw1 switches", sw_rand[2], dipsw1);
		dn_write(IDX_SWITCH, DN_ADDR_W'('h12), ~sw_rand[2]);
		check_byte("dipsw1 upper address", sw_rand[2], dipsw1);
		for (int i = 0; i < SWITCH_COUNT; i++)
			dn_write(IDX_SWITCH, DN_ADDR_W'(i), 8'hFF);

		test_name = "four-way filter";
		joy_p1 = JOY_W'(1) << JOY_UP;
		step(3);
		joy_p1 = (JOY_W'(1) << JOY_UP) | (JOY_W'(1) << JOY_RIGHT);
		step(3);
		check_byte("in0 newest right", 8'hFB, in0);
		joy_p1 = JOY_W'(1) << JOY_UP;
		step(2);
		check_byte("in0 right released", 8'hFE, in0);
		dn_write(IDX_VARIANT, '0, BYTE_W'(V_BIRD));
		joy_p1 = (JOY_W'(1) << JOY_UP) | (JOY_W'(1) << JOY_RIGHT);
		step(3);
		check_byte("in0 eight-way", 8'hFA, in0);

		test_name = "variant remapping";
		dn_write(IDX_SWITCH, DN_ADDR_W'(3), BYTE_W'($urandom));
		foreach (variant_list[i]) begin
			joy_p1 = JOY_W'($urandom);
			joy_p2 = JOY_W'($urandom);
			dn_write(IDX_VARIANT, '0, BYTE_W'(variant_list[i]));
			step(3);
		end
		// NUMCR swaps left and right
		joy_p1 = JOY_W'(1) << JOY_LEFT;
		joy_p2 = '0;
		dn_write(IDX_VARIANT, '0, BYTE_W'(V_NUMCR));
		step(3);
		check_byte("in0 numcr", 8'hBB, in0);
		// PMM puts fire on the p2 right bit and ignores the p2 stick
		joy_p1 = JOY_W'(1) << JOY_FIRE;
		joy_p2 = JOY_W'(1) << JOY_LEFT;
		dn_write(IDX_VARIANT, '0, BYTE_W'(V_PMM));
		step(3);
		check_byte("in1 pmm", 8'hFB, in1);
		joy_p1 = '0;
		joy_p2 = '0;
		dn_write(IDX_VARIANT, '0, BYTE_W'(V_PONP));
		step(3);
		check_byte("in0 ponp", 8'hE0, in0);
		check_byte("in1 ponp", 8'h00, in1);

		test_name = "unused code";
		joy_p1 = (JOY_W'(1) << JOY_FIRE) | (JOY_W'(1) << JOY_CHEAT);
		joy_p2 = JOY_W'(1) << JOY_FIRE;
		dn_write(IDX_VARIANT, '0, 8'd3);
		step(3);
		check_byte("in0 no variant", 8'hFF, in0);
		check_byte("in1 no variant", 8'hFF, in1);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/arcade_input_pkg.sv
hw/player_ctrl_if.sv
hw/clock_enables.sv
hw/download_regs.sv
hw/joy_one_dir.sv
hw/player_inputs.sv
hw/control_mapper.sv
hw/arcade_input_top.sv
testbench/tb_arcade_input.sv

// ==== Bender.yml ====
package:
  name: arcade_input

sources:
  - hw/arcade_input_pkg.sv
  - hw/player_ctrl_if.sv
  - hw/clock_enables.sv
  - hw/download_regs.sv
  - hw/joy_one_dir.sv
  - hw/player_inputs.sv
  - hw/control_mapper.sv
  - hw/arcade_input_top.sv
  - target: simulation
    files:
      - testbench/tb_arcade_input.sv
